//--- verilog/rf_defs.svh
// register-file execution unit sizing and address map macros
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// data path width in bits
`define RF_XLEN 32

// number of architectural registers, x0 included
`define RF_DEPTH 32

// axi4-lite address width
`define RF_AXI_AW 8

// write address of the instruction register
`define RF_INSTR_ADDR 'h00

`endif

//--- verilog/rf_pkg.sv
// shared types and rv32 opcode/funct encodings for the execution unit
`include "rf_defs.svh"

package rf_pkg;

    // one register value
    typedef logic [`RF_XLEN-1:0] rf_word_t;

    // register index, 32 entries
    typedef logic [4:0] rf_idx_t;

    // axi response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } rf_resp_e;

    // r-type layout
    typedef struct packed {
        logic [6:0] funct7;
        rf_idx_t    rs2;
        rf_idx_t    rs1;
        logic [2:0] funct3;
        rf_idx_t    rd;
        logic [6:0] opcode;
    } rf_rtype_t;

    // i-type layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        rf_idx_t     rs1;
        logic [2:0]  funct3;
        rf_idx_t     rd;
        logic [6:0]  opcode;
    } rf_itype_t;

    // one instruction word, view picked by opcode
    typedef union packed {
        rf_rtype_t r;
        rf_itype_t i;
    } rf_instr_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 for plain r-type ops, and for sub (bit 5 set)
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

//--- verilog/lutram_1w_mr.sv
// lutram-style register storage with one synchronous write port and n async read ports
`timescale 1ns/1ns

module lutram_1w_mr #(
    parameter int WIDTH          = 32,
    parameter int DEPTH          = 32,
    parameter int NUM_READ_PORTS = 2
) (
    input  logic                     clk,

    // write port
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic                     ram_write,
    input  logic [WIDTH-1:0]         new_ram_data,

    // read ports with one address and one data word each
    input  logic [$clog2(DEPTH)-1:0] raddr [NUM_READ_PORTS],
    output logic [WIDTH-1:0]         ram_data_out [NUM_READ_PORTS]
);

    logic [WIDTH-1:0] ram [DEPTH];

    // contents start cleared
    initial begin
        ram = '{default: '0};
    end

    // single write port captured on the rising edge
    always_ff @(posedge clk) begin
        if (ram_write) begin
            ram[waddr] <= new_ram_data;
        end
    end

    // every read port sees the array combinationally
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            ram_data_out[i] = ram[raddr[i]];
        end
    end

endmodule

//--- verilog/axil_cmd_slave.sv
// axi4-lite write slave, joins aw/w, issues instructions and builds b responses
`timescale 1ns/1ns
`include "rf_defs.svh"

module axil_cmd_slave
    import rf_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // write address channel
    input  logic [`RF_AXI_AW-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,

    // write data channel, strobes not used
    input  rf_word_t              wdata,
    input  logic                  wvalid,
    output logic                  wready,

    // write response channel
    output rf_resp_e              bresp,
    output logic                  bvalid,
    input  logic                  bready,

    // execute unit side
    output logic                  instr_valid,
    output rf_instr_u             instr,
    input  logic                  instr_done,
    input  logic                  illegal
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_RESP
    } state_t;

    state_t state;
    logic   aw_w_hs;
    logic   addr_ok;

    // both channels taken in the same cycle, only when idle
    assign awready = (state == S_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign aw_w_hs = awready;

    // only the instruction register is writable
    assign addr_ok = (awaddr == `RF_AXI_AW'(`RF_INSTR_ADDR));

    // response pending for the whole responding state
    assign bvalid = (state == S_RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            instr_valid <= 1'b0;
        end else begin
            // one-cycle pulse by default
            instr_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (aw_w_hs) begin
                        if (addr_ok) begin
                            instr_valid <= 1'b1;
                            state       <= S_EXEC;
                        end else begin
                            // bad address, answer straight away
                            state <= S_RESP;
                        end
                    end
                end
                S_EXEC: begin
                    // wait for write-back to commit
                    if (instr_done) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (bready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // instruction word and response code
    always_ff @(posedge clk) begin
        if (aw_w_hs) begin
            instr <= rf_instr_u'(wdata);
        end
        if (aw_w_hs && !addr_ok) begin
            bresp <= RESP_SLVERR;
        end else if (state == S_EXEC && instr_done) begin
            bresp <= illegal ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // response held steady until the master takes it
    bresp_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    // execute unit only answers an issued instruction
    done_in_exec_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_done |-> state == S_EXEC
    );

endmodule

//--- verilog/exec_unit.sv
// decode and execute for r-type and i-type alu ops with write-back
`timescale 1ns/1ns
`include "rf_defs.svh"

module exec_unit
    import rf_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // instruction handoff
    input  logic      instr_valid,
    input  rf_instr_u instr,
    output logic      instr_done,
    output logic      illegal,

    // operand reads
    output rf_idx_t   rf_raddr0,
    output rf_idx_t   rf_raddr1,
    input  rf_word_t  rf_rdata0,
    input  rf_word_t  rf_rdata1,

    // write-back
    output logic      rf_we,
    output rf_idx_t   rf_waddr,
    output rf_word_t  rf_wdata
);

    logic      valid_q;
    rf_instr_u instr_q;
    logic      is_op;
    logic      is_op_imm;
    logic      is_sub;
    logic      funct3_ok;
    logic      funct7_ok;
    logic      legal;
    rf_word_t  imm_ext;
    rf_word_t  op_a;
    rf_word_t  op_b;
    rf_word_t  result;

    // execute stage is busy the cycle after the handoff
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_q <= instr;
        end
    end

    // opcode picks the view since it sits at the same bits in both
    assign is_op     = (instr_q.r.opcode == OPC_OP);
    assign is_op_imm = (instr_q.i.opcode == OPC_OP_IMM);
    assign is_sub    = is_op && (instr_q.r.funct7 == F7_SUB);

    always_comb begin
        case (instr_q.r.funct3)
            F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND: funct3_ok = 1'b1;
            default:                               funct3_ok = 1'b0;
        endcase
    end

    // sub is the only r-type op with funct7 bit 5 set
    assign funct7_ok = (instr_q.r.funct7 == F7_BASE) ||
                       (is_sub && instr_q.r.funct3 == F3_ADD);
    assign legal = funct3_ok && (is_op_imm || (is_op && funct7_ok));

    // sign-extended immediate
    assign imm_ext = {{(`RF_XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};

    // x0 forced to zero on both operands
    assign op_a = (instr_q.r.rs1 == '0) ? '0 : rf_rdata0;
    always_comb begin
        if (is_op_imm) begin
            op_b = imm_ext;
        end else if (instr_q.r.rs2 == '0) begin
            op_b = '0;
        end else begin
            op_b = rf_rdata1;
        end
    end

    // alu
    always_comb begin
        case (instr_q.r.funct3)
            F3_ADD:  result = is_sub ? (op_a - op_b) : (op_a + op_b);
            F3_SLT:  result = rf_word_t'($signed(op_a) < $signed(op_b));
            F3_XOR:  result = op_a ^ op_b;
            F3_OR:   result = op_a | op_b;
            F3_AND:  result = op_a & op_b;
            default: result = '0;
        endcase
    end

    assign rf_raddr0 = instr_q.r.rs1;
    // for i-type this reads from imm bits and the value goes unused
    assign rf_raddr1 = instr_q.r.rs2;

    // no write for bad encodings or rd = x0
    assign rf_we      = valid_q && legal && (instr_q.r.rd != '0);
    assign rf_waddr   = instr_q.r.rd;
    assign rf_wdata   = result;
    assign instr_done = valid_q;
    assign illegal    = !legal;

    // an instruction handed over with rd = x0 never writes back
    no_x0_write_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid && instr.r.rd == '0 |=> !rf_we
    );

endmodule

//--- verilog/axil_read_port.sv
// axi4-lite read responder that returns one register per ar handshake
`timescale 1ns/1ns
`include "rf_defs.svh"

module axil_read_port
    import rf_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // read address channel
    input  logic [`RF_AXI_AW-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,

    // read data channel
    output rf_word_t              rdata,
    output rf_resp_e              rresp,
    output logic                  rvalid,
    input  logic                  rready,

    // register file readback port
    input  rf_word_t              rf_rdata2,
    output rf_idx_t               rf_raddr2
);

    logic ar_hs;

    assign ar_hs = arvalid && arready;

    // word index from the byte address
    assign rf_raddr2 = araddr[6:2];

    // every register read succeeds
    assign rresp = RESP_OKAY;

    // single-entry buffer that is ready again once the response is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end else if (ar_hs) begin
            rvalid  <= 1'b1;
            arready <= 1'b0;
        end else if (rvalid && rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    // sample the async read on the handshake edge
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rf_rdata2;
        end
    end

    // read data held steady until the master takes it
    rdata_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

//--- verilog/rf_exec_top.sv
// top level of the register-file execution unit behind an axi4-lite slave
`timescale 1ns/1ns
`include "rf_defs.svh"

module rf_exec_top
    import rf_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // write address channel
    input  logic [`RF_AXI_AW-1:0]     awaddr,
    input  logic                      awvalid,
    output logic                      awready,

    // write data channel
    input  rf_word_t                  wdata,
    input  logic [`RF_XLEN/8-1:0]     wstrb,
    input  logic                      wvalid,
    output logic                      wready,

    // write response channel
    output rf_resp_e                  bresp,
    output logic                      bvalid,
    input  logic                      bready,

    // read address channel
    input  logic [`RF_AXI_AW-1:0]     araddr,
    input  logic                      arvalid,
    output logic                      arready,

    // read data channel
    output rf_word_t                  rdata,
    output rf_resp_e                  rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    // two operand ports plus host readback
    localparam int NUM_RD = 3;

    logic      instr_valid;
    rf_instr_u instr;
    logic      instr_done;
    logic      illegal;
    rf_idx_t   rf_raddr [NUM_RD];
    rf_word_t  rf_rdata [NUM_RD];
    logic      rf_we;
    rf_idx_t   rf_waddr;
    rf_word_t  rf_wdata;

    // input side
    axil_cmd_slave u_axil_cmd_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_done  (instr_done),
        .illegal     (illegal)
    );

    // decode and alu
    exec_unit u_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_done  (instr_done),
        .illegal     (illegal),
        .rf_raddr0   (rf_raddr[0]),
        .rf_raddr1   (rf_raddr[1]),
        .rf_rdata0   (rf_rdata[0]),
        .rf_rdata1   (rf_rdata[1]),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata)
    );

    // host readback
    axil_read_port u_axil_read_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .rf_rdata2 (rf_rdata[2]),
        .rf_raddr2 (rf_raddr[2])
    );

    // register storage
    lutram_1w_mr #(
        .WIDTH          (`RF_XLEN),
        .DEPTH          (`RF_DEPTH),
        .NUM_READ_PORTS (NUM_RD)
    ) u_regfile (
        .clk          (clk),
        .waddr        (rf_waddr),
        .ram_write    (rf_we),
        .new_ram_data (rf_wdata),
        .raddr        (rf_raddr),
        .ram_data_out (rf_rdata)
    );

endmodule

//--- verification/tb_rf_exec.sv
// directed testbench for the register-file execution unit behind axi4-lite
`timescale 1ns/1ns
`include "rf_defs.svh"

module tb_rf_exec
    import rf_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic [`RF_AXI_AW-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    rf_word_t              wdata;
    logic [`RF_XLEN/8-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    rf_resp_e              bresp;
    logic                  bvalid;
    logic                  bready;
    logic [`RF_AXI_AW-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    rf_word_t              rdata;
    rf_resp_e              rresp;
    logic                  rvalid;
    logic                  rready;

    // reference register file where x0 is never written
    rf_word_t    ref_regs [`RF_DEPTH];
    logic [31:0] rng_state;
    logic [2:0]  f3_list [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    int          err_value = 0;
    int          err_other = 0;
    int          cycle_count = 0;
    int          txn_count = 0;
    int          stall_budget = 0;
    int          i;

    rf_exec_top u_rf_exec_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog allows 20 cycles per transaction plus requested stalls and reset slack
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 20 * txn_count + stall_budget + 100) begin
            $display("timeout: run stuck after %0d cycles, %0d transactions", cycle_count,
                     txn_count);
            $display("tests failed");
            $finish;
        end
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic rf_word_t sext12(input logic [11:0] imm);
        return {{(`RF_XLEN-12){imm[11]}}, imm};
    endfunction

    function automatic rf_word_t enc_r(input logic [6:0] f7, input rf_idx_t rs2,
                                       input rf_idx_t rs1, input logic [2:0] f3,
                                       input rf_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rf_word_t enc_i(input logic [11:0] imm, input rf_idx_t rs1,
                                       input logic [2:0] f3, input rf_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // rv32 alu rules that return legality and the value for rd
    function automatic logic model_exec(input rf_word_t iw, output rf_word_t val);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        rf_word_t   a;
        rf_word_t   b;
        logic       ok;
        opc = iw[6:0];
        f3  = iw[14:12];
        f7  = iw[31:25];
        a   = ref_regs[iw[19:15]];
        b   = (opc == 7'b0010011) ? sext12(iw[31:20]) : ref_regs[iw[24:20]];
        ok  = (f3 == 3'b000) || (f3 == 3'b010) || (f3 == 3'b100) ||
              (f3 == 3'b110) || (f3 == 3'b111);
        if (opc == 7'b0110011) begin
            ok = ok && ((f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b000));
        end else if (opc != 7'b0010011) begin
            ok = 1'b0;
        end
        case (f3)
            3'b000:  val = (opc == 7'b0110011 && f7 == 7'h20) ? a - b : a + b;
            3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  val = a ^ b;
            3'b110:  val = a | b;
            3'b111:  val = a & b;
            default: val = '0;
        endcase
        return ok;
    endfunction

    task automatic check_word(input string name, input rf_word_t got, input rf_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_resp(input string name, input rf_resp_e got, input rf_resp_e exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            err_value++;
        end
    endtask

    // one write with a fixed-latency check and bready held low for stall cycles
    task automatic axil_write(input logic [`RF_AXI_AW-1:0] addr, input rf_word_t data,
                              input rf_resp_e exp_resp, input int stall);
        int       lat;
        int       exp_lat;
        int       k;
        rf_resp_e held;
        txn_count++;
        stall_budget += stall;
        exp_lat = (addr == `RF_AXI_AW'(`RF_INSTR_ADDR)) ? 3 : 1;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        check_flag("wready", wready, 1'b1);
        @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        lat = 1;
        while (!bvalid) begin
            @(negedge clk);
            lat++;
        end
        if (lat != exp_lat) begin
            $display("write to %h answered after %0d cycles instead of %0d", addr, lat,
                     exp_lat);
            err_other++;
        end
        check_resp("bresp", bresp, exp_resp);
        held = bresp;
        for (k = 0; k < stall; k++) begin
            // a second write is offered but must wait for the response
            awaddr  = 8'h04;
            awvalid = 1'b1;
            wvalid  = 1'b1;
            #1;
            check_flag("awready", awready, 1'b0);
            check_flag("wready", wready, 1'b0);
            @(negedge clk);
            check_flag("bvalid", bvalid, 1'b1);
            check_resp("bresp", bresp, held);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(posedge clk);
        @(negedge clk);
        bready = 1'b0;
        check_flag("bvalid", bvalid, 1'b0);
    endtask

    // one register read with rready held low for stall cycles
    task automatic axil_read(input rf_idx_t idx, input int stall, output rf_word_t data);
        int k;
        txn_count++;
        stall_budget += stall;
        @(negedge clk);
        araddr  = {1'b0, idx, 2'b00};
        arvalid = 1'b1;
        rready  = 1'b0;
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        check_resp("rresp", rresp, RESP_OKAY);
        for (k = 0; k < stall; k++) begin
            araddr  = {1'b0, ~idx, 2'b00};
            arvalid = 1'b1;
            check_flag("arready", arready, 1'b0);
            @(negedge clk);
            check_flag("rvalid", rvalid, 1'b1);
            check_word("rdata", rdata, data);
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(posedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_instr(input rf_word_t iw, input int stall);
        rf_word_t val;
        logic     ok;
        ok = model_exec(iw, val);
        axil_write(`RF_AXI_AW'(`RF_INSTR_ADDR), iw, ok ? RESP_OKAY : RESP_SLVERR, stall);
        if (ok && iw[11:7] != 5'd0) begin
            ref_regs[iw[11:7]] = val;
        end
    endtask

    task automatic verify_reg(input rf_idx_t idx, input int stall);
        rf_word_t got;
        axil_read(idx, stall, got);
        check_word($sformatf("x%0d", idx), got, ref_regs[idx]);
    endtask

    task automatic test_reset_state();
        check_flag("bvalid", bvalid, 1'b0);
        check_flag("rvalid", rvalid, 1'b0);
        check_flag("arready", arready, 1'b1);
        for (i = 0; i < `RF_DEPTH; i++) begin
            verify_reg(rf_idx_t'(i), 0);
        end
    endtask

    task automatic test_imm_ops();
        logic [31:0] r;
        repeat (24) begin
            r = next_rand();
            write_instr(enc_i(r[31:20], r[4:0], f3_list[int'(r[13:10]) % 5], r[9:5]),
                        int'(next_rand() % 3));
            verify_reg(r[9:5], 0);
        end
    endtask

    task automatic test_reg_ops();
        logic [31:0] r;
        int          op;
        // fill every register with a sign-extended random value
        for (i = 1; i < `RF_DEPTH; i++) begin
            r = next_rand();
            write_instr(enc_i(r[31:20], 5'd0, 3'b000, rf_idx_t'(i)), 0);
        end
        repeat (24) begin
            r  = next_rand();
            op = int'(next_rand() % 6);
            if (op == 0) begin
                write_instr(enc_r(7'h20, r[14:10], r[19:15], 3'b000, r[24:20]), 0);
            end else begin
                write_instr(enc_r(7'h00, r[14:10], r[19:15], f3_list[op - 1], r[24:20]),
                            int'(next_rand() % 3));
            end
            verify_reg(r[24:20], 0);
        end
    endtask

    task automatic test_x0();
        write_instr(enc_i(12'h07b, 5'd5, 3'b000, 5'd0), 0);
        verify_reg(5'd0, 0);
        write_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 0);
        verify_reg(5'd0, 0);
        // x0 as an operand reads zero
        write_instr(enc_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd7), 0);
        verify_reg(5'd7, 0);
        write_instr(enc_r(7'h20, 5'd0, 5'd4, 3'b000, 5'd8), 0);
        verify_reg(5'd8, 0);
        write_instr(enc_r(7'h00, 5'd4, 5'd0, 3'b010, 5'd9), 0);
        verify_reg(5'd9, 0);
    endtask

    task automatic test_errors();
        // load opcode, shift funct3, xor with the sub funct7
        write_instr(32'h0000_2083, 1);
        write_instr(enc_i(12'h001, 5'd1, 3'b001, 5'd2), 0);
        write_instr(enc_r(7'h20, 5'd3, 5'd4, 3'b100, 5'd5), 0);
        // legal word at addresses other than the instruction register
        axil_write(8'h04, enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3), RESP_SLVERR, 1);
        axil_write(8'h80, enc_i(12'h123, 5'd0, 3'b000, 5'd6), RESP_SLVERR, 0);
        for (i = 0; i < `RF_DEPTH; i++) begin
            verify_reg(rf_idx_t'(i), 0);
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        rf_idx_t     rd;
        repeat (6) begin
            r  = next_rand();
            rd = (r[9:5] == 5'd0) ? 5'd1 : r[9:5];
            write_instr(enc_i(r[31:20], r[4:0], 3'b110, rd), 3 + int'(next_rand() % 5));
            verify_reg(rd, 3 + int'(next_rand() % 5));
        end
        axil_write(8'h08, 32'hdead_beef, RESP_SLVERR, 5);
        verify_reg(rd, 6);
    endtask

    initial begin
        rng_state = 32'd82312;
        ref_regs  = '{default: '0};
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '1;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_imm_ops();
        test_reg_ops();
        test_x0();
        test_errors();
        test_backpressure();
        $display("errors: %0d value mismatches, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/rf_pkg.sv
verilog/lutram_1w_mr.sv
verilog/axil_cmd_slave.sv
verilog/exec_unit.sv
verilog/axil_read_port.sv
verilog/rf_exec_top.sv
verification/tb_rf_exec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_rf_exec \
    -Mdir obj_dir -o sim_tb_rf_exec \
    && ./obj_dir/sim_tb_rf_exec > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
